//--- flist.f
+incdir+common
common/axiPkg.sv
common/memReqPkg.sv
design/transferTable/transferTable.sv
design/readChannel.sv
design/writeChannel.sv
design/memCtrlTop.sv
testbench/axiSlaveModel.sv
testbench/memCtrlTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module memCtrlTb -o memCtrlSim \
    && ./obj_dir/memCtrlSim > sim.log 2>&1 \
    || echo "build or simulation ended with an error status"
cat sim.log 2>/dev/null
grep -q "Something failed" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0

//--- testbench/memCtrlTb.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module memCtrlTb;

    logic clk;
    logic rst;
    logic reqValid, reqWrite, reqReady, respValid, respWrite;
    logic [1:0] reqSize;
    logic [`MC_ADDR_W-1:0] reqAddr, araddr, awaddr;
    logic [`MC_DATA_W-1:0] reqData, respData, rdata, wdata;
    logic [`MC_TAG_W-1:0] reqTag, respTag;
    logic arvalid, arready, rvalid, rready, rlast;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [`MC_ID_W-1:0] arid, rid, awid, bid;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst;
    logic [`MC_DATA_W/8-1:0] wstrb;
    logic stall, reverse;
    logic [1:0] gap;

    // expected memory contents by word index
    logic [`MC_DATA_W-1:0] shadow [64];
    logic [`MC_DATA_W-1:0] expData [256];
    logic expWrite [256];
    logic pending [256];
    // request size by low address byte
    logic [1:0] sizeAt [256];
    logic [`MC_TAG_W+`MC_DATA_W:0] respQ [$];
    logic [`MC_TAG_W-1:0] nextTag;
    int cycles = 0;

    memCtrlTop memCtrlTop_i (.*);

    axiSlaveModel axiMem_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycles);
            $display("Something failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    // each respValid pulse queues one response
    always @(negedge clk) begin
        if (respValid) begin
            respQ.push_back({respWrite, respTag, respData});
        end
    end

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    endtask

    // single-beat FIXED bursts sized like the request
    always @(negedge clk) begin
        if (arvalid) begin
            checkEqual(32'(arlen), 32'd0, "arlen");
            checkEqual(32'(arburst), 32'd0, "arburst");
            checkEqual(32'(arsize), 32'(sizeAt[araddr[7:0]]), "arsize");
        end
        if (awvalid) begin
            checkEqual(32'(awlen), 32'd0, "awlen");
            checkEqual(32'(awburst), 32'd0, "awburst");
            checkEqual(32'(awsize), 32'(sizeAt[awaddr[7:0]]), "awsize");
        end
        if (wvalid) begin
            checkEqual(32'(wlast), 32'd1, "wlast");
        end
    end

    function automatic logic [31:0] mergeBytes(input logic [31:0] word, input logic [1:0] off,
                                               input logic [1:0] size, input logic [31:0] data);
        int count;
        count = 1 << size;
        for (int b = 0; b < count; b++) begin
            word[8 * (off + b) +: 8] = data[8 * b +: 8];
        end
        return word;
    endfunction

    function automatic logic [31:0] laneValue(input logic [31:0] word, input logic [1:0] off,
                                              input logic [1:0] size);
        case (size)
            `MC_SIZE_BYTE: return {24'd0, word[8 * off +: 8]};
            `MC_SIZE_HALF: return {16'd0, word[8 * off +: 16]};
            default: return word;
        endcase
    endfunction

    // called and returns 2 ns after a rising edge
    task automatic sendReq(input logic write, input logic [1:0] size, input logic [31:0] addr,
                           input logic [31:0] data);
        if (write) begin
            shadow[addr[7:2]] = mergeBytes(shadow[addr[7:2]], addr[1:0], size, data);
        end
        expWrite[nextTag] = write;
        expData[nextTag] = write ? 32'd0 : laneValue(shadow[addr[7:2]], addr[1:0], size);
        pending[nextTag] = 1'b1;
        sizeAt[addr[7:0]] = size;
        reqValid = 1'b1;
        reqWrite = write;
        reqSize = size;
        reqAddr = addr;
        reqData = data;
        reqTag = nextTag;
        nextTag = nextTag + 1'b1;
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        reqValid = 1'b0;
    endtask

    task automatic collect(input int n);
        logic [`MC_TAG_W+`MC_DATA_W:0] r;
        logic [`MC_TAG_W-1:0] t;
        while (respQ.size() < n) begin
            @(posedge clk);
            #2;
        end
        repeat (n) begin
            r = respQ.pop_front();
            t = r[`MC_DATA_W +: `MC_TAG_W];
            checkEqual(32'(pending[t]), 32'd1, "response tag not outstanding");
            checkEqual(32'(r[`MC_TAG_W+`MC_DATA_W]), 32'(expWrite[t]), "respWrite");
            checkEqual(r[`MC_DATA_W-1:0], expData[t], "respData");
            pending[t] = 1'b0;
        end
    endtask

    task automatic fillWords(input logic [31:0] base, input int count);
        for (int i = 0; i < count; i++) begin
            sendReq(1'b1, `MC_SIZE_WORD, base + 4 * i, 32'h9e37_79b9 * (base + i + 1));
            collect(1);
        end
    endtask

    task automatic wordRoundTrip();
        gap = 2'($urandom);
        sendReq(1'b1, `MC_SIZE_WORD, 32'h40, 32'hcafe_f00d);
        collect(1);
        sendReq(1'b0, `MC_SIZE_WORD, 32'h40, 32'd0);
        collect(1);
    endtask

    task automatic laneReads();
        gap = 2'($urandom);
        sendReq(1'b1, `MC_SIZE_WORD, 32'h84, 32'h8a6b_4c2d);
        collect(1);
        for (int off = 0; off < 4; off++) begin
            sendReq(1'b0, `MC_SIZE_BYTE, 32'h84 + off, 32'd0);
            collect(1);
        end
        sendReq(1'b0, `MC_SIZE_HALF, 32'h84, 32'd0);
        sendReq(1'b0, `MC_SIZE_HALF, 32'h86, 32'd0);
        collect(2);
    endtask

    task automatic partialWrites();
        gap = 2'($urandom);
        sendReq(1'b1, `MC_SIZE_WORD, 32'hc8, 32'h1122_3344);
        collect(1);
        // upper data bits must not leak into other lanes
        sendReq(1'b1, `MC_SIZE_BYTE, 32'hc9, 32'hffff_ffa5);
        collect(1);
        sendReq(1'b1, `MC_SIZE_HALF, 32'hca, 32'hffff_5ab6);
        collect(1);
        sendReq(1'b0, `MC_SIZE_WORD, 32'hc8, 32'd0);
        collect(1);
    endtask

    task automatic reverseOrder();
        logic [`MC_TAG_W-1:0] first;
        gap = 2'($urandom);
        fillWords(32'h10, 4);
        reverse = 1'b1;
        first = nextTag;
        for (int i = 0; i < 4; i++) begin
            sendReq(1'b0, `MC_SIZE_WORD, 32'h10 + 4 * i, 32'd0);
        end
        while (respQ.size() < 4) begin
            @(posedge clk);
            #2;
        end
        // slots fill from 0 upwards and the model answers the highest ID first
        for (int i = 0; i < 4; i++) begin
            checkEqual(32'(respQ[i][`MC_DATA_W +: `MC_TAG_W]), 32'(first) + 3 - i,
                       "reverse answer order");
        end
        collect(4);
        reverse = 1'b0;
    endtask

    task automatic stallFull();
        gap = 2'($urandom);
        fillWords(32'h20, 5);
        stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            sendReq(1'b0, `MC_SIZE_WORD, 32'h20 + 4 * i, 32'd0);
        end
        @(negedge clk);
        checkEqual(32'(reqReady), 32'd0, "reqReady with a full table");
        @(posedge clk);
        #2;
        stall = 1'b0;
        sendReq(1'b0, `MC_SIZE_WORD, 32'h30, 32'd0);
        collect(5);
    endtask

    task automatic mixedTraffic();
        gap = 2'($urandom);
        sendReq(1'b1, `MC_SIZE_WORD, 32'h60, 32'h0bad_beef);
        sendReq(1'b0, `MC_SIZE_WORD, 32'h14, 32'd0);
        collect(2);
        sendReq(1'b0, `MC_SIZE_HALF, 32'h62, 32'd0);
        sendReq(1'b1, `MC_SIZE_BYTE, 32'h1b, 32'h0000_0077);
        collect(2);
    endtask

    initial begin
        void'($urandom(32'h926c_b8cd));
        rst = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqSize = 2'd0;
        reqAddr = '0;
        reqData = '0;
        reqTag = '0;
        stall = 1'b0;
        reverse = 1'b0;
        gap = 2'd0;
        nextTag = 8'h10;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        wordRoundTrip();
        laneReads();
        partialWrites();
        reverseOrder();
        stallFull();
        mixedTraffic();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- testbench/axiSlaveModel.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module axiSlaveModel (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      reverse,
    input  logic [1:0]                gap,

    input  logic                      arvalid,
    output logic                      arready,
    input  logic [`MC_ID_W-1:0]       arid,
    input  logic [`MC_ADDR_W-1:0]     araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output logic [`MC_ID_W-1:0]       rid,
    output logic [`MC_DATA_W-1:0]     rdata,
    output logic                      rlast,

    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`MC_ID_W-1:0]       awid,
    input  logic [`MC_ADDR_W-1:0]     awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [`MC_DATA_W-1:0]     wdata,
    input  logic [`MC_DATA_W/8-1:0]   wstrb,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [`MC_ID_W-1:0]       bid
);

    logic [7:0]                  mem [256];
    logic [`MC_ID_W+7:0]         rdQ [$];
    logic [`MC_ID_W+7:0]         awQ [$];
    logic [`MC_DATA_W+3:0]       wQ [$];
    logic [`MC_ID_W-1:0]         bQ [$];
    logic [1:0]                  phase;
    logic                        draining;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5a;
        end
        phase = 2'd0;
        draining = 1'b0;
        rvalid = 1'b0;
        rid = '0;
        rdata = '0;
        bvalid = 1'b0;
        bid = '0;
    end

    // ready for one clock out of every gap+1
    assign arready = !stall && phase == 2'd0;
    assign awready = arready;
    assign wready = arready;
    assign rlast = 1'b1;

    always @(posedge clk) begin : respond
        logic [`MC_ID_W+7:0]   ent;
        logic [`MC_DATA_W+3:0] beat;
        if (rst) begin
            phase <= 2'd0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            draining = 1'b0;
            rdQ.delete();
            awQ.delete();
            wQ.delete();
            bQ.delete();
        end else begin
            phase <= (phase >= gap) ? 2'd0 : phase + 2'd1;
            if (arvalid && arready) begin
                rdQ.push_back({arid, araddr[7:0]});
            end
            if (awvalid && awready) begin
                awQ.push_back({awid, awaddr[7:0]});
            end
            if (wvalid && wready) begin
                wQ.push_back({wstrb, wdata});
            end
            // a write lands once its address and data are both here
            if (awQ.size() != 0 && wQ.size() != 0) begin
                ent = awQ.pop_front();
                beat = wQ.pop_front();
                for (int b = 0; b < 4; b++) begin
                    if (beat[`MC_DATA_W + b]) begin
                        mem[{ent[7:2], 2'(b)}] = beat[8 * b +: 8];
                    end
                end
                bQ.push_back(ent[`MC_ID_W+7:8]);
            end
            if (!bvalid || bready) begin
                bvalid <= bQ.size() != 0;
                if (bQ.size() != 0) begin
                    bid <= bQ.pop_front();
                end
            end
            // reverse mode collects a full batch, then answers newest first
            if (reverse && rdQ.size() == `MC_SLOTS) begin
                draining = 1'b1;
            end
            if (!rvalid || rready) begin
                rvalid <= 1'b0;
                if (rdQ.size() != 0 && (!reverse || draining)) begin
                    if (reverse) begin
                        ent = rdQ.pop_back();
                    end else begin
                        ent = rdQ.pop_front();
                    end
                    rvalid <= 1'b1;
                    rid <= ent[`MC_ID_W+7:8];
                    rdata <= {mem[{ent[7:2], 2'd3}], mem[{ent[7:2], 2'd2}],
                              mem[{ent[7:2], 2'd1}], mem[{ent[7:2], 2'd0}]};
                end
                if (rdQ.size() == 0) begin
                    draining = 1'b0;
                end
            end
        end
    end

endmodule

//--- design/memCtrlTop.sv
`timescale 1ns/1ps

module memCtrlTop
    import axiPkg::*;
    import memReqPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      reqValid,
    input  logic      reqWrite,
    input  memSize_t  reqSize,
    input  axiAddr_t  reqAddr,
    input  axiData_t  reqData,
    input  memTag_t   reqTag,
    output logic      reqReady,

    output logic      respValid,
    output logic      respWrite,
    output memTag_t   respTag,
    output axiData_t  respData,

    output logic      arvalid,
    input  logic      arready,
    output axiId_t    arid,
    output axiAddr_t  araddr,
    output axiLen_t   arlen,
    output axiSize_t  arsize,
    output axiBurst_t arburst,

    input  logic      rvalid,
    output logic      rready,
    input  axiId_t    rid,
    input  axiData_t  rdata,
    input  logic      rlast,

    output logic      awvalid,
    input  logic      awready,
    output axiId_t    awid,
    output axiAddr_t  awaddr,
    output axiLen_t   awlen,
    output axiSize_t  awsize,
    output axiBurst_t awburst,

    output logic      wvalid,
    input  logic      wready,
    output axiData_t  wdata,
    output axiStrb_t  wstrb,
    output logic      wlast,

    input  logic      bvalid,
    output logic      bready,
    input  axiId_t    bid
);

    logic     rdIssueValid;
    logic     rdIssueReady;
    slotIdx_t rdIssueSlot;
    axiAddr_t rdIssueAddr;
    memSize_t rdIssueSize;

    logic     wrIssueValid;
    logic     wrIssueReady;
    slotIdx_t wrIssueSlot;
    axiAddr_t wrIssueAddr;
    memSize_t wrIssueSize;
    axiData_t wrIssueData;

    logic     rdDoneValid;
    logic     rdDoneReady;
    slotIdx_t rdDoneSlot;
    axiData_t rdDoneData;

    logic     wrDoneValid;
    logic     wrDoneReady;
    slotIdx_t wrDoneSlot;

    transferTable transferTable_i (.*);

    readChannel readChannel_i (.*);

    writeChannel writeChannel_i (.*);

endmodule

//--- design/writeChannel.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module writeChannel
    import axiPkg::*;
    import memReqPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      wrIssueValid,
    input  slotIdx_t  wrIssueSlot,
    input  axiAddr_t  wrIssueAddr,
    input  memSize_t  wrIssueSize,
    input  axiData_t  wrIssueData,
    output logic      wrIssueReady,

    output logic      wrDoneValid,
    output slotIdx_t  wrDoneSlot,
    input  logic      wrDoneReady,

    output logic      awvalid,
    input  logic      awready,
    output axiId_t    awid,
    output axiAddr_t  awaddr,
    output axiLen_t   awlen,
    output axiSize_t  awsize,
    output axiBurst_t awburst,

    output logic      wvalid,
    input  logic      wready,
    output axiData_t  wdata,
    output axiStrb_t  wstrb,
    output logic      wlast,

    input  logic      bvalid,
    output logic      bready,
    input  axiId_t    bid
);

    laneOff_t laneOff;
    axiData_t lowData;
    axiStrb_t lowStrb;
    logic     issueFire;
    logic     bFire;

    // AW and W leave together, so wait for both to drain
    assign wrIssueReady = !awvalid && !wvalid;
    assign issueFire = wrIssueValid && wrIssueReady;

    assign awlen = '0;
    assign awburst = AXI_BURST_FIXED;
    assign wlast = 1'b1;

    always_comb begin
        laneOff = laneOff_t'(wrIssueAddr);
        case (wrIssueSize)
            `MC_SIZE_BYTE: begin
                lowData = axiData_t'(wrIssueData[7:0]);
                lowStrb = axiStrb_t'(4'b0001);
            end
            `MC_SIZE_HALF: begin
                lowData = axiData_t'(wrIssueData[15:0]);
                lowStrb = axiStrb_t'(4'b0011);
            end
            default: begin
                lowData = wrIssueData;
                lowStrb = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else if (issueFire) begin
            awvalid <= 1'b1;
            wvalid <= 1'b1;
        end else begin
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            awid <= axiId_t'(wrIssueSlot);
            awaddr <= wrIssueAddr;
            awsize <= axiSize_t'(wrIssueSize);
            wdata <= lowData << {laneOff, 3'b000};
            wstrb <= lowStrb << laneOff;
        end
    end

    assign bready = !wrDoneValid;
    assign bFire = bvalid && bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrDoneValid <= 1'b0;
        end else if (bFire) begin
            wrDoneValid <= 1'b1;
        end else if (wrDoneReady) begin
            wrDoneValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bFire) begin
            wrDoneSlot <= slotIdx_t'(bid);
        end
    end

    wHold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

//--- design/readChannel.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module readChannel
    import axiPkg::*;
    import memReqPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      rdIssueValid,
    input  slotIdx_t  rdIssueSlot,
    input  axiAddr_t  rdIssueAddr,
    input  memSize_t  rdIssueSize,
    output logic      rdIssueReady,

    output logic      rdDoneValid,
    output slotIdx_t  rdDoneSlot,
    output axiData_t  rdDoneData,
    input  logic      rdDoneReady,

    output logic      arvalid,
    input  logic      arready,
    output axiId_t    arid,
    output axiAddr_t  araddr,
    output axiLen_t   arlen,
    output axiSize_t  arsize,
    output axiBurst_t arburst,

    input  logic      rvalid,
    output logic      rready,
    input  axiId_t    rid,
    input  axiData_t  rdata,
    input  logic      rlast
);

    // per slot, needed to align data when R comes back
    laneOff_t slotOff [`MC_SLOTS];
    memSize_t slotSize [`MC_SLOTS];

    logic     issueFire;
    logic     beatFire;
    axiData_t shifted;
    axiData_t aligned;

    assign rdIssueReady = !arvalid;
    assign issueFire = rdIssueValid && rdIssueReady;

    // single beat, fixed burst
    assign arlen = '0;
    assign arburst = AXI_BURST_FIXED;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (issueFire) begin
            arvalid <= 1'b1;
        end else if (arready) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            arid <= axiId_t'(rdIssueSlot);
            araddr <= rdIssueAddr;
            arsize <= axiSize_t'(rdIssueSize);
            slotOff[rdIssueSlot] <= laneOff_t'(rdIssueAddr);
            slotSize[rdIssueSlot] <= rdIssueSize;
        end
    end

    assign rready = !rdDoneValid;
    assign beatFire = rvalid && rready;

    // move the addressed lane down to bit 0, zero extended
    always_comb begin
        shifted = rdata >> {slotOff[rid], 3'b000};
        case (slotSize[rid])
            `MC_SIZE_BYTE: aligned = axiData_t'(shifted[7:0]);
            `MC_SIZE_HALF: aligned = axiData_t'(shifted[15:0]);
            default: aligned = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdDoneValid <= 1'b0;
        end else if (beatFire && rlast) begin
            rdDoneValid <= 1'b1;
        end else if (rdDoneReady) begin
            rdDoneValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beatFire) begin
            rdDoneSlot <= slotIdx_t'(rid);
            rdDoneData <= aligned;
        end
    end

    arHold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid));

endmodule

//--- design/transferTable/transferTable.sv
`timescale 1ns/1ps
`include "memCtrl_cfg.svh"

module transferTable
    import axiPkg::*;
    import memReqPkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     reqValid,
    input  logic     reqWrite,
    input  memSize_t reqSize,
    input  axiAddr_t reqAddr,
    input  axiData_t reqData,
    input  memTag_t  reqTag,
    output logic     reqReady,

    output logic     rdIssueValid,
    output slotIdx_t rdIssueSlot,
    output axiAddr_t rdIssueAddr,
    output memSize_t rdIssueSize,
    input  logic     rdIssueReady,

    output logic     wrIssueValid,
    output slotIdx_t wrIssueSlot,
    output axiAddr_t wrIssueAddr,
    output memSize_t wrIssueSize,
    output axiData_t wrIssueData,
    input  logic     wrIssueReady,

    input  logic     rdDoneValid,
    input  slotIdx_t rdDoneSlot,
    input  axiData_t rdDoneData,
    output logic     rdDoneReady,

    input  logic     wrDoneValid,
    input  slotIdx_t wrDoneSlot,
    output logic     wrDoneReady,

    output logic     respValid,
    output logic     respWrite,
    output memTag_t  respTag,
    output axiData_t respData
);

    logic     slotValid [`MC_SLOTS];
    logic     slotNeedIssue [`MC_SLOTS];
    logic     slotWrite [`MC_SLOTS];
    memSize_t slotSize [`MC_SLOTS];
    axiAddr_t slotAddr [`MC_SLOTS];
    axiData_t slotData [`MC_SLOTS];
    memTag_t  slotTag [`MC_SLOTS];

    // low until the first clock out of reset
    logic     running;

    logic     anyFree;
    slotIdx_t allocIdx;
    slotIdx_t rdSel;
    slotIdx_t wrSel;
    logic     reqAccept;
    logic     rdAccept;
    logic     wrAccept;

    // walk downwards so the lowest index wins
    always_comb begin
        anyFree = 1'b0;
        allocIdx = '0;
        rdIssueValid = 1'b0;
        rdSel = '0;
        wrIssueValid = 1'b0;
        wrSel = '0;
        for (int i = `MC_SLOTS - 1; i >= 0; i--) begin
            if (!slotValid[i]) begin
                anyFree = 1'b1;
                allocIdx = slotIdx_t'(i);
            end
            if (slotValid[i] && slotNeedIssue[i] && !slotWrite[i]) begin
                rdIssueValid = 1'b1;
                rdSel = slotIdx_t'(i);
            end
            if (slotValid[i] && slotNeedIssue[i] && slotWrite[i]) begin
                wrIssueValid = 1'b1;
                wrSel = slotIdx_t'(i);
            end
        end
    end

    assign reqReady = running && anyFree;
    assign reqAccept = reqValid && reqReady;

    assign rdIssueSlot = rdSel;
    assign rdIssueAddr = slotAddr[rdSel];
    assign rdIssueSize = slotSize[rdSel];

    assign wrIssueSlot = wrSel;
    assign wrIssueAddr = slotAddr[wrSel];
    assign wrIssueSize = slotSize[wrSel];
    assign wrIssueData = slotData[wrSel];

    // read completions always go first
    assign rdDoneReady = 1'b1;
    assign wrDoneReady = !rdDoneValid;
    assign rdAccept = rdDoneValid && rdDoneReady;
    assign wrAccept = wrDoneValid && wrDoneReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            respValid <= 1'b0;
            for (int i = 0; i < `MC_SLOTS; i++) begin
                slotValid[i] <= 1'b0;
                slotNeedIssue[i] <= 1'b0;
            end
        end else begin
            running <= 1'b1;
            respValid <= rdAccept || wrAccept;
            if (reqAccept) begin
                slotValid[allocIdx] <= 1'b1;
                slotNeedIssue[allocIdx] <= 1'b1;
            end
            if (rdIssueValid && rdIssueReady) begin
                slotNeedIssue[rdSel] <= 1'b0;
            end
            if (wrIssueValid && wrIssueReady) begin
                slotNeedIssue[wrSel] <= 1'b0;
            end
            if (rdAccept) begin
                slotValid[rdDoneSlot] <= 1'b0;
            end else if (wrAccept) begin
                slotValid[wrDoneSlot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqAccept) begin
            slotWrite[allocIdx] <= reqWrite;
            slotSize[allocIdx] <= reqSize;
            slotAddr[allocIdx] <= reqAddr;
            slotData[allocIdx] <= reqData;
            slotTag[allocIdx] <= reqTag;
        end
        if (rdAccept) begin
            respWrite <= 1'b0;
            respTag <= slotTag[rdDoneSlot];
            respData <= rdDoneData;
        end else if (wrAccept) begin
            respWrite <= 1'b1;
            respTag <= slotTag[wrDoneSlot];
            respData <= '0;
        end
    end

    // a channel only completes slots it was handed and already issued
    rdDoneKind: assert property (@(posedge clk) disable iff (rst)
        rdDoneValid |-> slotValid[rdDoneSlot] && !slotWrite[rdDoneSlot]
                        && !slotNeedIssue[rdDoneSlot]);

    wrDoneKind: assert property (@(posedge clk) disable iff (rst)
        wrDoneValid |-> slotValid[wrDoneSlot] && slotWrite[wrDoneSlot]
                        && !slotNeedIssue[wrDoneSlot]);

    // no completion can race a fresh allocation of the same slot
    allocFree: assert property (@(posedge clk) disable iff (rst)
        reqAccept |-> !slotValid[allocIdx]
                      && !(rdDoneValid && rdDoneSlot == allocIdx)
                      && !(wrDoneValid && wrDoneSlot == allocIdx));

endmodule

//--- common/memReqPkg.sv
`include "memCtrl_cfg.svh"

package memReqPkg;

    // slot index doubles as the AXI ID
    typedef logic [`MC_ID_W-1:0] slotIdx_t;

    typedef logic [`MC_TAG_W-1:0] memTag_t;

    // byte, half or word
    typedef logic [1:0] memSize_t;

    // byte lane within a data word
    typedef logic [$clog2(`MC_DATA_W/8)-1:0] laneOff_t;

endpackage

//--- common/axiPkg.sv
`include "memCtrl_cfg.svh"

package axiPkg;

    typedef logic [`MC_ADDR_W-1:0] axiAddr_t;
    typedef logic [`MC_DATA_W-1:0] axiData_t;
    typedef logic [`MC_DATA_W/8-1:0] axiStrb_t;
    typedef logic [`MC_ID_W-1:0] axiId_t;
    typedef logic [2:0] axiSize_t;
    typedef logic [7:0] axiLen_t;
    typedef logic [1:0] axiBurst_t;

    // burst encodings
    localparam axiBurst_t AXI_BURST_FIXED = 2'b00;
    localparam axiBurst_t AXI_BURST_INCR = 2'b01;

endpackage

//--- common/memCtrl_cfg.svh
`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// bus widths
`define MC_ADDR_W 32
`define MC_DATA_W 32

// transfers in flight, one AXI ID per slot
`define MC_SLOTS 4
`define MC_ID_W 2

`define MC_TAG_W 8

// access sizes, same codes as AXI size
`define MC_SIZE_BYTE 2'd0
`define MC_SIZE_HALF 2'd1
`define MC_SIZE_WORD 2'd2

`endif
